// File: memPkg.sv
package memPkg;

	// SRAM geometry
	localparam int AddrWidth = 18;
	localparam int DataWidth = 16;

	// Cycles spent in each access phase, 1 through 8 are valid
	localparam int PhaseTicks = 2;
	localparam int PhaseCntWidth = 3;

	typedef logic [AddrWidth-1:0] memAddrT;
	typedef logic [DataWidth-1:0] memDataT;
	typedef logic [PhaseCntWidth-1:0] phaseCntT;

	// Three phases per access, read and write paths kept apart
	typedef enum logic [2:0] {
		idle,
		readSetup,
		readEnable,
		readSample,
		writeSetup,
		writePulse,
		writeRelease
	} ctrlStateT;

	typedef enum logic {
		grantExe,
		grantFetch
	} grantT;

endpackage

// File: reqLatch.sv
`timescale 1ns/1ps

module reqLatch (
	input  logic             clk,
	input  logic             rst,
	input  logic             fetchReq,
	input  memPkg::memAddrT  fetchAddr,
	input  logic             exeReq,
	input  logic             exeWrite,
	input  memPkg::memAddrT  exeAddr,
	input  memPkg::memDataT  exeWdata,
	input  logic             accept,
	input  memPkg::grantT    grant,
	output logic             fetchPending,
	output logic             exePending,
	output logic             exeWriteHeld,
	output memPkg::memAddrT  selAddr,
	output memPkg::memDataT  selWdata
);
	import memPkg::*;

	memAddrT fetchAddrHeld;
	memAddrT exeAddrHeld;
	memDataT exeWdataHeld;
	logic fetchAccept;
	logic exeAccept;

	assign fetchAccept = accept && (grant == grantFetch);
	assign exeAccept = accept && (grant == grantExe);

	// One entry per port, the write flag clears together with its entry
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fetchPending <= 1'b0;
			exePending <= 1'b0;
			exeWriteHeld <= 1'b0;
		end else begin
			if (fetchAccept) begin
				fetchPending <= 1'b0;
			end
			if (fetchReq) begin
				fetchPending <= 1'b1;
			end
			if (exeAccept) begin
				exePending <= 1'b0;
				exeWriteHeld <= 1'b0;
			end
			if (exeReq) begin
				exePending <= 1'b1;
				exeWriteHeld <= exeWrite;
			end
		end
	end

	// Request payload, only valid in the strobe cycle
	always_ff @(posedge clk) begin
		if (fetchReq) begin
			fetchAddrHeld <= fetchAddr;
		end
		if (exeReq) begin
			exeAddrHeld <= exeAddr;
			exeWdataHeld <= exeWdata;
		end
	end

	assign selAddr = (grant == grantExe) ? exeAddrHeld : fetchAddrHeld;
	assign selWdata = exeWdataHeld;

	//////////////////////////////////////////////////
	// Requester rules

	noExeReqWhilePending: assert property (@(posedge clk) disable iff (!rst)
		exeReq |-> !exePending)
		else $error("execute request while previous one still pending");

	noFetchReqWhilePending: assert property (@(posedge clk) disable iff (!rst)
		fetchReq |-> !fetchPending)
		else $error("fetch request while previous one still pending");

	// A fetch is only served with no execute write waiting
	fetchNeverWrites: assert property (@(posedge clk) disable iff (!rst)
		fetchAccept |-> !exeWriteHeld)
		else $error("fetch granted while an execute write is held");

endmodule

// File: memCtrl.sv
`timescale 1ns/1ps

module memCtrl (
	input  logic               clk,
	input  logic               rst,
	input  logic               fetchPending,
	input  logic               exePending,
	input  logic               exeWriteHeld,
	output memPkg::ctrlStateT  state,
	output memPkg::grantT      grant,
	output logic               accept,
	output logic               phaseEnd
);
	import memPkg::*;

	ctrlStateT nextState;
	grantT arbGrant;
	grantT grantHeld;
	phaseCntT phaseCnt;

	// Execute port wins over fetch
	assign arbGrant = exePending ? grantExe : grantFetch;
	assign accept = (state == idle) && (exePending || fetchPending);

	// Live arbitration in idle, frozen for the rest of the access
	assign grant = (state == idle) ? arbGrant : grantHeld;

	assign phaseEnd = (state != idle) && (phaseCnt == phaseCntT'(PhaseTicks - 1));

	//////////////////////////////////////////////////
	// Phase pacing

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			phaseCnt <= '0;
		end else if (state == idle || phaseEnd) begin
			phaseCnt <= '0;
		end else begin
			phaseCnt <= phaseCnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			grantHeld <= grantExe;
		end else if (accept) begin
			grantHeld <= arbGrant;
		end
	end

	//////////////////////////////////////////////////
	// Access sequencing

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (accept) begin
					if (arbGrant == grantExe && exeWriteHeld) begin
						nextState = writeSetup;
					end else begin
						nextState = readSetup;
					end
				end
			end
			// Phases only advance on the last tick
			readSetup: if (phaseEnd) nextState = readEnable;
			readEnable: if (phaseEnd) nextState = readSample;
			readSample: if (phaseEnd) nextState = idle;
			writeSetup: if (phaseEnd) nextState = writePulse;
			writePulse: if (phaseEnd) nextState = writeRelease;
			writeRelease: if (phaseEnd) nextState = idle;
			default: nextState = idle;
		endcase
	end

	// Three phases of PhaseTicks each, then back in idle
	accessLength: assert property (@(posedge clk) disable iff (!rst)
		accept |-> ##(3 * PhaseTicks) (state != idle) ##1 (state == idle))
		else $error("access did not last three phases");

endmodule

// File: ramPins.sv
`timescale 1ns/1ps

module ramPins (
	input  logic               clk,
	input  logic               rst,
	input  memPkg::ctrlStateT  state,
	input  logic               accept,
	input  memPkg::memAddrT    selAddr,
	input  memPkg::memDataT    selWdata,
	output memPkg::memAddrT    ramAddr,
	output logic               ramEn,
	output logic               ramOe,
	output logic               ramWe,
	output memPkg::memDataT    ramWdata,
	output logic               ramDrive
);
	import memPkg::*;

	logic isWrite;

	assign isWrite = (state == writeSetup) || (state == writePulse) ||
		(state == writeRelease);

	// Address and data stay put for the whole access
	always_ff @(posedge clk) begin
		if (accept) begin
			ramAddr <= selAddr;
			ramWdata <= selWdata;
		end
	end

	//////////////////////////////////////////////////
	// Control pins, active low, one cycle behind state

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			ramEn <= 1'b1;
			ramOe <= 1'b1;
			ramWe <= 1'b1;
			ramDrive <= 1'b0;
		end else begin
			ramEn <= (state == idle);
			ramOe <= !((state == readEnable) || (state == readSample));
			// Write strobe sits inside setup and release
			ramWe <= (state != writePulse);
			ramDrive <= isWrite;
		end
	end

	// Chip must never see output and write enable together
	noOeWeOverlap: assert property (@(posedge clk) disable iff (!rst)
		!(!ramOe && !ramWe))
		else $error("ramOe and ramWe both low");

endmodule

// File: readCapture.sv
`timescale 1ns/1ps

module readCapture (
	input  logic               clk,
	input  logic               rst,
	input  memPkg::ctrlStateT  state,
	input  memPkg::grantT      grant,
	input  logic               phaseEnd,
	input  memPkg::memDataT    ramRdata,
	output logic               fetchDone,
	output logic               exeDone,
	output memPkg::memDataT    fetchData,
	output memPkg::memDataT    exeRdata
);
	import memPkg::*;

	logic readDone;
	logic writeDone;
	logic accessDone;

	assign readDone = phaseEnd && (state == readSample);
	assign writeDone = phaseEnd && (state == writeRelease);
	assign accessDone = readDone || writeDone;

	// Separate result registers per port
	always_ff @(posedge clk) begin
		if (readDone && grant == grantExe) begin
			exeRdata <= ramRdata;
		end
		if (readDone && grant == grantFetch) begin
			fetchData <= ramRdata;
		end
	end

	// Done strobes, one cycle each
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			fetchDone <= 1'b0;
			exeDone <= 1'b0;
		end else begin
			fetchDone <= accessDone && (grant == grantFetch);
			exeDone <= accessDone && (grant == grantExe);
		end
	end

endmodule

// File: memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem (
	input  logic             clk,
	input  logic             rst,
	// Fetch port
	input  logic             fetchReq,
	input  memPkg::memAddrT  fetchAddr,
	output logic             fetchDone,
	output memPkg::memDataT  fetchData,
	// Execute port
	input  logic             exeReq,
	input  logic             exeWrite,
	input  memPkg::memAddrT  exeAddr,
	input  memPkg::memDataT  exeWdata,
	output logic             exeDone,
	output memPkg::memDataT  exeRdata,
	// SRAM pins, data pad split for the board wrapper
	output memPkg::memAddrT  ramAddr,
	output logic             ramEn,
	output logic             ramOe,
	output logic             ramWe,
	output memPkg::memDataT  ramWdata,
	output logic             ramDrive,
	input  memPkg::memDataT  ramRdata
);
	import memPkg::*;

	logic fetchPending;
	logic exePending;
	logic exeWriteHeld;
	logic accept;
	logic phaseEnd;
	grantT grant;
	ctrlStateT state;
	memAddrT selAddr;
	memDataT selWdata;

	reqLatch reqLatch_i (
		.clk(clk), .rst(rst),
		.fetchReq(fetchReq), .fetchAddr(fetchAddr),
		.exeReq(exeReq), .exeWrite(exeWrite), .exeAddr(exeAddr), .exeWdata(exeWdata),
		.accept(accept), .grant(grant),
		.fetchPending(fetchPending), .exePending(exePending), .exeWriteHeld(exeWriteHeld),
		.selAddr(selAddr), .selWdata(selWdata)
	);

	memCtrl memCtrl_i (
		.clk(clk), .rst(rst),
		.fetchPending(fetchPending), .exePending(exePending), .exeWriteHeld(exeWriteHeld),
		.state(state), .grant(grant), .accept(accept), .phaseEnd(phaseEnd)
	);

	ramPins ramPins_i (
		.clk(clk), .rst(rst),
		.state(state), .accept(accept), .selAddr(selAddr), .selWdata(selWdata),
		.ramAddr(ramAddr), .ramEn(ramEn), .ramOe(ramOe), .ramWe(ramWe),
		.ramWdata(ramWdata), .ramDrive(ramDrive)
	);

	readCapture readCapture_i (
		.clk(clk), .rst(rst),
		.state(state), .grant(grant), .phaseEnd(phaseEnd), .ramRdata(ramRdata),
		.fetchDone(fetchDone), .exeDone(exeDone), .fetchData(fetchData), .exeRdata(exeRdata)
	);

endmodule

// File: sramModel.sv
`timescale 1ns/1ps

module sramModel (
	input  memPkg::memAddrT  ramAddr,
	input  logic             ramEn,
	input  logic             ramOe,
	input  logic             ramWe,
	input  memPkg::memDataT  ramWdata,
	input  logic             ramDrive,
	output memPkg::memDataT  ramRdata
);
	import memPkg::*;

	memDataT mem [0:(1 << AddrWidth) - 1];

	// Power-up contents, every address bit takes part
	function automatic memDataT fillWord(input memAddrT a);
		return {a[7:0], a[15:8]} ^ {a[17:16], 14'h1e5b};
	endfunction

	initial begin
		for (int a = 0; a < (1 << AddrWidth); a++) begin
			mem[a] = fillWord(memAddrT'(a));
		end
	end

	// Word is stored when the write strobe rises
	always @(posedge ramWe) begin
		if (!ramEn && ramDrive) begin
			mem[ramAddr] = ramWdata;
		end
	end

	// Asynchronous read, floating bus when not selected
	assign ramRdata = (!ramEn && !ramOe) ? mem[ramAddr] : 'x;

endmodule

// File: tbMemSubsystem.sv
`timescale 1ns/1ps

module tbMemSubsystem;
	import memPkg::*;

	localparam logic [31:0] Seed = 32'h035a0069;
	localparam int DirectedTrans = 8;
	localparam int RandTrans = 200;
	// Each transaction may wait behind one on the other port
	localparam int TimeoutCycles = 16 +
		(DirectedTrans + RandTrans) * (2 * (2 + 3 * PhaseTicks) + 4);

	logic clk;
	logic rst;
	logic fetchReq;
	memAddrT fetchAddr;
	logic fetchDone;
	memDataT fetchData;
	logic exeReq;
	logic exeWrite;
	memAddrT exeAddr;
	memDataT exeWdata;
	logic exeDone;
	memDataT exeRdata;
	memAddrT ramAddr;
	logic ramEn;
	logic ramOe;
	logic ramWe;
	logic ramDrive;
	memDataT ramWdata;
	memDataT ramRdata;

	logic [31:0] lfsr;
	memDataT shadow [256];
	logic exeExpRead [$];
	memDataT exeExpData [$];
	memDataT fetchExpData [$];
	int fetchNeedExe [$];
	int exeIssued = 0;
	int fetchIssued = 0;
	int exeDoneCount = 0;
	int fetchDoneCount = 0;
	int checkCount = 0;
	int errorCount = 0;
	int cycleCount = 0;
	memDataT lastExeRdata;
	logic haveExeRdata = 1'b0;

	memSubsystem dut_i (.*);
	sramModel sram_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Random source and reference model

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hd0000001) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Same power-up rule as the SRAM model
	function automatic memDataT powerUpWord(input memAddrT a);
		return {a[7:0], a[15:8]} ^ {a[17:16], 14'h1e5b};
	endfunction

	function automatic memDataT refWord(input memAddrT a);
		return shadow[a[7:0]];
	endfunction

	//////////////////////////////////////////////////
	// Request drivers

	task automatic nextCycle();
		@(posedge clk);
		exeReq <= 1'b0;
		fetchReq <= 1'b0;
	endtask

	task automatic issueExe(input logic wr, input memAddrT a, input memDataT d);
		exeReq <= 1'b1;
		exeWrite <= wr;
		exeAddr <= a;
		exeWdata <= d;
		if (wr) begin
			shadow[a[7:0]] = d;
		end
		exeExpRead.push_back(!wr);
		exeExpData.push_back(refWord(a));
		exeIssued++;
	endtask

	// afterExe marks a fetch issued in the same cycle as an execute request
	task automatic issueFetch(input memAddrT a, input logic afterExe);
		fetchReq <= 1'b1;
		fetchAddr <= a;
		fetchExpData.push_back(refWord(a));
		fetchNeedExe.push_back(afterExe ? exeIssued : 0);
		fetchIssued++;
	endtask

	task automatic waitIdle();
		while (exeIssued != exeDoneCount || fetchIssued != fetchDoneCount) begin
			nextCycle();
		end
	endtask

	//////////////////////////////////////////////////
	// Checking

	task automatic reportMismatch(input string msg);
		errorCount++;
		$display("FAILED at %0d ns: %s", $time, msg);
	endtask

	task automatic reportProblem(input string msg);
		errorCount++;
		$display("%s (at %0d ns)", msg, $time);
	endtask

	task automatic checkPins();
		if (exeIssued == 0 && fetchIssued == 0) begin
			checkCount++;
			if (!ramEn || !ramOe || !ramWe || ramDrive || fetchDone || exeDone) begin
				reportMismatch($sformatf("idle pins en=%b oe=%b we=%b drive=%b",
					ramEn, ramOe, ramWe, ramDrive));
			end
		end
		if (!ramOe && !ramWe) begin
			reportMismatch("ramOe and ramWe both low");
		end
		if (!ramWe && !ramDrive) begin
			reportMismatch("ramWe low while ramDrive is low");
		end
	endtask

	task automatic checkExeDone();
		memDataT expected;
		if (exeDoneCount >= exeIssued) begin
			reportProblem("Execute done strobe arrived with no execute request outstanding");
		end else begin
			expected = exeExpData[exeDoneCount];
			checkCount++;
			if (exeExpRead[exeDoneCount] && exeRdata !== expected) begin
				reportMismatch($sformatf("exeRdata %h, expected %h", exeRdata, expected));
			end
			exeDoneCount++;
		end
		lastExeRdata = exeRdata;
		haveExeRdata = 1'b1;
	endtask

	task automatic checkFetchDone();
		memDataT expected;
		if (fetchDoneCount >= fetchIssued) begin
			reportProblem("Fetch done strobe arrived with no fetch request outstanding");
		end else begin
			expected = fetchExpData[fetchDoneCount];
			checkCount++;
			if (fetchData !== expected) begin
				reportMismatch($sformatf("fetchData %h, expected %h", fetchData, expected));
			end
			if (exeDoneCount < fetchNeedExe[fetchDoneCount]) begin
				reportProblem("Fetch finished before the execute request issued with it");
			end
			if (haveExeRdata && exeRdata !== lastExeRdata) begin
				reportMismatch($sformatf("exeRdata moved to %h during a fetch", exeRdata));
			end
			fetchDoneCount++;
		end
	endtask

	// Outputs settle after the rising edge, so look at them on the falling edge
	always @(negedge clk) begin
		if (rst) begin
			checkPins();
			if (exeDone) begin
				checkExeDone();
			end
			if (fetchDone) begin
				checkFetchDone();
			end
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout after %0d cycles with requests still outstanding", cycleCount);
			$display("Errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Stimulus

	initial begin
		logic wr;
		logic exeNow;
		memAddrT addr;
		memDataT data;
		int randIssued;
		rst = 1'b0;
		fetchReq = 1'b0;
		fetchAddr = '0;
		exeReq = 1'b0;
		exeWrite = 1'b0;
		exeAddr = '0;
		exeWdata = '0;
		lfsr = Seed;
		randIssued = 0;
		for (int i = 0; i < 256; i++) begin
			shadow[i] = powerUpWord(memAddrT'(i));
		end
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		repeat (4) nextCycle();

		// Execute write, then read it back
		nextCycle();
		issueExe(1'b1, 18'h021, 16'hc3a5);
		waitIdle();
		nextCycle();
		issueExe(1'b0, 18'h021, '0);
		waitIdle();

		// Fetch of a freshly written word
		nextCycle();
		issueExe(1'b1, 18'h042, 16'h7e18);
		waitIdle();
		nextCycle();
		issueFetch(18'h042, 1'b0);
		waitIdle();

		// Both ports in one cycle, execute goes first
		nextCycle();
		issueExe(1'b0, 18'h021, '0);
		issueFetch(18'h042, 1'b1);
		waitIdle();
		nextCycle();
		issueExe(1'b1, 18'h042, 16'h0ff0);
		issueFetch(18'h042, 1'b1);
		waitIdle();

		// Mixed random traffic, one outstanding request per port
		while (randIssued < RandTrans) begin
			nextCycle();
			exeNow = 1'b0;
			if (exeIssued == exeDoneCount && randBits(1) != 0) begin
				wr = randBits(1) != 0;
				addr = memAddrT'(randBits(8));
				data = memDataT'(randBits(16));
				issueExe(wr, addr, data);
				exeNow = 1'b1;
				randIssued++;
			end
			if (randIssued < RandTrans && fetchIssued == fetchDoneCount &&
				randBits(1) != 0) begin
				addr = memAddrT'(randBits(8));
				issueFetch(addr, exeNow);
				randIssued++;
			end
		end
		waitIdle();
		repeat (2) nextCycle();

		$display("Transactions %0d, checks %0d, errors %0d",
			exeIssued + fetchIssued, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: vlog.f
memPkg.sv
reqLatch.sv
memCtrl.sv
ramPins.sv
readCapture.sv
memSubsystem.sv
sramModel.sv
tbMemSubsystem.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f vlog.f --top-module tbMemSubsystem

log=$(./obj_dir/VtbMemSubsystem)
printf '%s\n' "$log"
printf '%s\n' "$log" | grep -qx "No errors"
